// File: exec_pkg.sv
package exec_pkg;

	// Data and address width
	localparam int XLEN = 64;

	// Entries in each valid/ready queue
	localparam int FIFO_DEPTH = 2;

	// Instruction class after decode
	typedef enum logic [2:0] {
		INST_R,
		INST_I,
		INST_B,
		INST_U,
		INST_J
	} itype_t;

	// ALU operation by funct3
	localparam logic [2:0] ALU_ADD  = 3'b000;
	localparam logic [2:0] ALU_SLL  = 3'b001;
	localparam logic [2:0] ALU_SLT  = 3'b010;
	localparam logic [2:0] ALU_SLTU = 3'b011;
	localparam logic [2:0] ALU_XOR  = 3'b100;
	localparam logic [2:0] ALU_SR   = 3'b101;
	localparam logic [2:0] ALU_OR   = 3'b110;
	localparam logic [2:0] ALU_AND  = 3'b111;

	// Branch condition by funct3
	localparam logic [2:0] BR_EQ  = 3'b000;
	localparam logic [2:0] BR_NE  = 3'b001;
	localparam logic [2:0] BR_LT  = 3'b100;
	localparam logic [2:0] BR_GE  = 3'b101;
	localparam logic [2:0] BR_LTU = 3'b110;
	localparam logic [2:0] BR_GEU = 3'b111;

	// Instruction address misaligned
	localparam logic [3:0] EXPT_INSTR_MISALIGNED = 4'd0;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		itype_t          itype;
		logic [2:0]      funct3;
		logic            alt;
		logic            is_jump;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
		logic [XLEN-1:0] imm;
	} exec_req_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] result;
		logic            br_taken;
		logic [XLEN-1:0] jump_addr;
		logic            expt_valid;
		logic [3:0]      expt_cause;
		logic [XLEN-1:0] expt_value;
	} exec_resp_t;

endpackage

// File: exec_if.sv
`timescale 1ns/1ps

interface exec_if ();
	import exec_pkg::*;

	// Dequeued request, driven by the merge stage
	logic            req_valid;
	exec_req_t       req;
	// High in the cycle the request leaves the queue
	logic            ack;

	// ALU side
	logic [XLEN-1:0] alu_result;

	// Branch unit side
	logic            cond;
	logic [XLEN-1:0] br_target;
	logic [XLEN-1:0] link;

	modport alu_mp (
		input  req_valid,
		input  req,
		input  ack,
		output alu_result
	);

	modport branch_mp (
		input  req,
		output cond,
		output br_target,
		output link
	);

	modport merge_mp (
		output req_valid,
		output req,
		output ack,
		input  alu_result,
		input  cond,
		input  br_target,
		input  link
	);

endinterface

// File: op_fifo.sv
`timescale 1ns/1ps

module op_fifo #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     i_wvalid,
	output logic     o_wready,
	input  payload_t i_wdata,
	output logic     o_rvalid,
	input  logic     i_rready,
	output payload_t o_rdata
);
	import exec_pkg::*;

	payload_t                        mem [FIFO_DEPTH];
	logic [$clog2(FIFO_DEPTH)-1:0]   wptr;
	logic [$clog2(FIFO_DEPTH)-1:0]   rptr;
	logic [$clog2(FIFO_DEPTH+1)-1:0] count;
	logic                            full;
	logic                            wr_en;
	logic                            rd_en;

	assign full     = (count == FIFO_DEPTH);
	// A full queue still takes a write when the head leaves in the same cycle
	assign o_wready = !full || i_rready;
	assign o_rvalid = (count != '0);
	assign o_rdata  = mem[rptr];
	assign wr_en    = i_wvalid && o_wready;
	assign rd_en    = o_rvalid && i_rready;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wptr] <= i_wdata;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wptr <= (wptr == FIFO_DEPTH - 1) ? '0 : wptr + 1'b1;
			end
			if (rd_en) begin
				rptr <= (rptr == FIFO_DEPTH - 1) ? '0 : rptr + 1'b1;
			end
			// Entry count
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (!rst) full && wr_en |=> full
	) else $error("op_fifo: write accepted while full");

	a_count_in_range: assert property (
		@(posedge clk) disable iff (!rst) count <= FIFO_DEPTH
	) else $error("op_fifo: entry count above depth");

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input logic   clk,
	input logic   rst,
	exec_if.alu_mp bus
);
	import exec_pkg::*;

	logic [XLEN-1:0] op1;
	logic [XLEN-1:0] op2;
	logic [5:0]      shamt;
	logic            sub_en;
	logic [XLEN-1:0] sra;

	// Operand selection
	always_comb begin
		case (bus.req.itype)
			INST_R: begin
				op1 = bus.req.rs1;
				op2 = bus.req.rs2;
			end
			INST_I: begin
				op1 = bus.req.rs1;
				op2 = bus.req.imm;
			end
			INST_B, INST_U, INST_J: begin
				op1 = bus.req.pc;
				op2 = bus.req.imm;
			end
			default: begin
				op1 = '0;
				op2 = '0;
			end
		endcase
	end

	assign shamt  = op2[5:0];
	assign sub_en = bus.req.alt && (bus.req.itype == INST_R);
	// Arithmetic shift right
	assign sra    = $signed(op1) >>> shamt;

	always_comb begin
		if (bus.req.itype == INST_R || bus.req.itype == INST_I) begin
			case (bus.req.funct3)
				ALU_ADD:  bus.alu_result = sub_en ? op1 - op2 : op1 + op2;
				ALU_SLL:  bus.alu_result = op1 << shamt;
				ALU_SLT:  bus.alu_result = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
				ALU_SLTU: bus.alu_result = {{(XLEN-1){1'b0}}, op1 < op2};
				ALU_XOR:  bus.alu_result = op1 ^ op2;
				ALU_SR:   bus.alu_result = bus.req.alt ? sra : op1 >> shamt;
				ALU_OR:   bus.alu_result = op1 | op2;
				ALU_AND:  bus.alu_result = op1 & op2;
				default:  bus.alu_result = op1 + op2;
			endcase
		end else begin
			// pc plus imm for AUIPC, JAL and branches
			bus.alu_result = op1 + op2;
		end
	end

	a_itype_known: assert property (
		@(posedge clk) disable iff (!rst)
		bus.req_valid |-> bus.req.itype inside {INST_R, INST_I, INST_B, INST_U, INST_J}
	) else $error("alu: itype outside the enum");

	// The queue head must not change while it waits for the response queue
	a_req_held: assert property (
		@(posedge clk) disable iff (!rst)
		bus.req_valid && !bus.ack |=> bus.req_valid && $stable(bus.req)
	) else $error("alu: request changed before it was taken");

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
	exec_if.branch_mp bus
);
	import exec_pkg::*;

	// Branch condition on rs1 versus rs2
	always_comb begin
		case (bus.req.funct3)
			BR_EQ:   bus.cond = (bus.req.rs1 == bus.req.rs2);
			BR_NE:   bus.cond = (bus.req.rs1 != bus.req.rs2);
			BR_LT:   bus.cond = ($signed(bus.req.rs1) < $signed(bus.req.rs2));
			BR_GE:   bus.cond = ($signed(bus.req.rs1) >= $signed(bus.req.rs2));
			BR_LTU:  bus.cond = (bus.req.rs1 < bus.req.rs2);
			BR_GEU:  bus.cond = (bus.req.rs1 >= bus.req.rs2);
			default: bus.cond = 1'b0;
		endcase
	end

	// Target of a taken branch
	assign bus.br_target = bus.req.pc + bus.req.imm;

	// Return address written by JAL and JALR
	assign bus.link = bus.req.pc + XLEN'(4);

endmodule

// File: exec_merge.sv
`timescale 1ns/1ps

module exec_merge (
	input  logic                 clk,
	input  logic                 rst,
	exec_if.merge_mp             bus,
	input  logic                 i_req_valid,
	input  exec_pkg::exec_req_t  i_req,
	output logic                 o_req_ready,
	output logic                 o_resp_valid,
	output exec_pkg::exec_resp_t o_resp,
	input  logic                 i_resp_ready
);
	import exec_pkg::*;

	logic            is_br;
	logic [XLEN-1:0] jump_addr;

	// Request leaves its queue exactly when the response enters the next one
	assign bus.req_valid = i_req_valid;
	assign bus.req       = i_req;
	assign bus.ack       = i_req_valid && i_resp_ready;
	assign o_resp_valid  = i_req_valid;
	assign o_req_ready   = i_resp_ready;

	assign is_br     = (i_req.itype == INST_B);
	assign jump_addr = is_br ? bus.br_target : {bus.alu_result[XLEN-1:1], 1'b0};

	always_comb begin
		o_resp.pc         = i_req.pc;
		o_resp.result     = i_req.is_jump ? bus.link : bus.alu_result;
		o_resp.br_taken   = i_req.is_jump || (is_br && bus.cond);
		o_resp.jump_addr  = jump_addr;
		// Taken target must be 4-byte aligned
		o_resp.expt_valid = o_resp.br_taken && (jump_addr[1:0] != 2'b00);
		o_resp.expt_cause = EXPT_INSTR_MISALIGNED;
		o_resp.expt_value = o_resp.expt_valid ? jump_addr : '0;
	end

	// A response waiting for room in the output queue keeps its contents
	a_resp_held: assert property (
		@(posedge clk) disable iff (!rst)
		o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp)
	) else $error("exec_merge: response changed before it was taken");

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      i_valid,
	output logic                      o_ready,
	input  logic [exec_pkg::XLEN-1:0] i_pc,
	input  exec_pkg::itype_t          i_itype,
	input  logic [2:0]                i_funct3,
	input  logic                      i_alt,
	input  logic                      i_is_jump,
	input  logic [exec_pkg::XLEN-1:0] i_rs1,
	input  logic [exec_pkg::XLEN-1:0] i_rs2,
	input  logic [exec_pkg::XLEN-1:0] i_imm,
	output logic                      o_valid,
	input  logic                      i_ready,
	output logic [exec_pkg::XLEN-1:0] o_pc,
	output logic [exec_pkg::XLEN-1:0] o_result,
	output logic                      o_br_taken,
	output logic [exec_pkg::XLEN-1:0] o_jump_addr,
	output logic                      o_expt_valid,
	output logic [3:0]                o_expt_cause,
	output logic [exec_pkg::XLEN-1:0] o_expt_value
);
	import exec_pkg::*;

	exec_req_t  req_in;
	exec_req_t  req_q;
	logic       req_q_valid;
	logic       req_q_ready;
	exec_resp_t resp_d;
	logic       resp_d_valid;
	logic       resp_d_ready;
	exec_resp_t resp_q;

	exec_if ex_bus ();

	// Pack the input ports
	assign req_in.pc      = i_pc;
	assign req_in.itype   = i_itype;
	assign req_in.funct3  = i_funct3;
	assign req_in.alt     = i_alt;
	assign req_in.is_jump = i_is_jump;
	assign req_in.rs1     = i_rs1;
	assign req_in.rs2     = i_rs2;
	assign req_in.imm     = i_imm;

	op_fifo #(.payload_t(exec_req_t)) req_fifo (
		.clk      (clk),
		.rst      (rst),
		.i_wvalid (i_valid),
		.o_wready (o_ready),
		.i_wdata  (req_in),
		.o_rvalid (req_q_valid),
		.i_rready (req_q_ready),
		.o_rdata  (req_q)
	);

	alu alu_i (
		.clk (clk),
		.rst (rst),
		.bus (ex_bus.alu_mp)
	);

	branch_unit branch_unit_i (
		.bus (ex_bus.branch_mp)
	);

	exec_merge exec_merge_i (
		.clk          (clk),
		.rst          (rst),
		.bus          (ex_bus.merge_mp),
		.i_req_valid  (req_q_valid),
		.i_req        (req_q),
		.o_req_ready  (req_q_ready),
		.o_resp_valid (resp_d_valid),
		.o_resp       (resp_d),
		.i_resp_ready (resp_d_ready)
	);

	op_fifo #(.payload_t(exec_resp_t)) resp_fifo (
		.clk      (clk),
		.rst      (rst),
		.i_wvalid (resp_d_valid),
		.o_wready (resp_d_ready),
		.i_wdata  (resp_d),
		.o_rvalid (o_valid),
		.i_rready (i_ready),
		.o_rdata  (resp_q)
	);

	// Unpack the response onto the output ports
	assign o_pc         = resp_q.pc;
	assign o_result     = resp_q.result;
	assign o_br_taken   = resp_q.br_taken;
	assign o_jump_addr  = resp_q.jump_addr;
	assign o_expt_valid = resp_q.expt_valid;
	assign o_expt_cause = resp_q.expt_cause;
	assign o_expt_value = resp_q.expt_value;

endmodule

// File: tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;
	import exec_pkg::*;

	localparam int N_ISO          = 6;
	localparam int N_RAND         = 200;
	localparam int N_TOTAL        = N_ISO + N_RAND;
	localparam int TIMEOUT_CYCLES = N_TOTAL * 6 + 100;

	logic            clk;
	logic            rst;
	logic            i_valid;
	logic            o_ready;
	logic [XLEN-1:0] i_pc;
	itype_t          i_itype;
	logic [2:0]      i_funct3;
	logic            i_alt;
	logic            i_is_jump;
	logic [XLEN-1:0] i_rs1;
	logic [XLEN-1:0] i_rs2;
	logic [XLEN-1:0] i_imm;
	logic            o_valid;
	logic            i_ready;
	logic [XLEN-1:0] o_pc;
	logic [XLEN-1:0] o_result;
	logic            o_br_taken;
	logic [XLEN-1:0] o_jump_addr;
	logic            o_expt_valid;
	logic [3:0]      o_expt_cause;
	logic [XLEN-1:0] o_expt_value;

	logic [31:0] lcg_state = 32'd30063;
	logic        rand_ready = 1'b0;
	int          cycles = 0;
	int          acc_cnt = 0;
	int          rcv_cnt = 0;
	int          exp_cnt = 0;
	exec_req_t   in_req;
	exec_resp_t  exp_q [$];
	exec_resp_t  exp_head = '0;

	exec_unit exec_unit_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Expected response built from the execute rules
	function automatic exec_resp_t expect_resp(input exec_req_t rq);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] alu_val;
		logic [XLEN-1:0] target;
		logic [5:0]      sh;
		logic            cond;
		exec_resp_t      rs;
		a = (rq.itype == INST_R || rq.itype == INST_I) ? rq.rs1 : rq.pc;
		b = (rq.itype == INST_R) ? rq.rs2 : rq.imm;
		sh = b[5:0];
		alu_val = a + b;
		if (rq.itype == INST_R || rq.itype == INST_I) begin
			case (rq.funct3)
				3'b000: alu_val = (rq.alt && rq.itype == INST_R) ? a - b : a + b;
				3'b001: alu_val = a << sh;
				3'b010: alu_val = {63'b0, $signed(a) < $signed(b)};
				3'b011: alu_val = {63'b0, a < b};
				3'b100: alu_val = a ^ b;
				3'b101: begin
					if (rq.alt)
						alu_val = $signed(a) >>> sh;
					else
						alu_val = a >> sh;
				end
				3'b110: alu_val = a | b;
				default: alu_val = a & b;
			endcase
		end
		case (rq.funct3)
			3'b000: cond = (rq.rs1 == rq.rs2);
			3'b001: cond = (rq.rs1 != rq.rs2);
			3'b100: cond = $signed(rq.rs1) < $signed(rq.rs2);
			3'b101: cond = $signed(rq.rs1) >= $signed(rq.rs2);
			3'b110: cond = rq.rs1 < rq.rs2;
			3'b111: cond = rq.rs1 >= rq.rs2;
			default: cond = 1'b0;
		endcase
		target = (rq.itype == INST_B) ? rq.pc + rq.imm : {alu_val[XLEN-1:1], 1'b0};
		rs.pc         = rq.pc;
		rs.result     = rq.is_jump ? rq.pc + 64'd4 : alu_val;
		rs.br_taken   = rq.is_jump || (rq.itype == INST_B && cond);
		rs.jump_addr  = target;
		rs.expt_valid = rs.br_taken && (target[1:0] != 2'b00);
		rs.expt_cause = 4'd0;
		rs.expt_value = target;
		return rs;
	endfunction

	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("** Error: %s expected 0x%h, actual 0x%h", name, exp, got);
		stop_run();
	endtask

	task automatic fail_text(input string why);
		$display("Error: %s", why);
		stop_run();
	endtask

	task automatic next_cycle();
		@(negedge clk);
		if (rand_ready)
			i_ready = (next_rand() % 3) != 0;
	endtask

	// Random request of any class with aligned offsets about three times in four
	task automatic make_request(input int idx);
		logic [31:0] r;
		logic [31:0] r2;
		int          sel;
		r = next_rand();
		r2 = next_rand();
		i_pc      = 64'h0000_0040_8000_0000 + (64'(idx) << 2);
		i_itype   = itype_t'(r % 5);
		i_funct3  = r[2:0];
		i_alt     = r[3];
		i_is_jump = 1'b0;
		i_rs1     = {next_rand(), next_rand()};
		i_rs2     = (r[5:4] == 2'b00) ? i_rs1 : {next_rand(), next_rand()};
		i_imm     = {{52{r2[11]}}, r2[11:0]};
		if (r2[13:12] != 2'b00)
			i_imm[1:0] = 2'b00;
		case (i_itype)
			INST_B: begin
				sel = r[10:8] % 6;
				i_funct3 = (sel < 2) ? 3'(sel) : 3'(sel + 2);
			end
			INST_I: begin
				if (r[9:8] == 2'b00) begin
					// JALR
					i_is_jump = 1'b1;
					i_funct3  = 3'b000;
					i_alt     = 1'b0;
					if (r2[13:12] != 2'b00)
						i_rs1[1:0] = 2'b00;
				end
			end
			INST_J: i_is_jump = 1'b1;
			default: ;
		endcase
	endtask

	task automatic send_request(input int idx);
		make_request(idx);
		i_valid = 1'b1;
		do
			next_cycle();
		while (acc_cnt != idx + 1);
	endtask

	always_comb begin
		in_req.pc      = i_pc;
		in_req.itype   = i_itype;
		in_req.funct3  = i_funct3;
		in_req.alt     = i_alt;
		in_req.is_jump = i_is_jump;
		in_req.rs1     = i_rs1;
		in_req.rs2     = i_rs2;
		in_req.imm     = i_imm;
	end

	// Head entry of the scoreboard is the next expected output
	always @(posedge clk) begin
		if (rst) begin
			if (o_valid && i_ready) begin
				if (exp_q.size() != 0)
					void'(exp_q.pop_front());
				rcv_cnt <= rcv_cnt + 1;
			end
			if (i_valid && o_ready) begin
				exp_q.push_back(expect_resp(in_req));
				acc_cnt <= acc_cnt + 1;
			end
			exp_cnt  <= exp_q.size();
			exp_head <= (exp_q.size() != 0) ? exp_q[0] : '0;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			fail_text("timeout, the DUT stopped producing outputs");
	end

	a_reset_state: assert property (@(posedge clk) $rose(rst) |-> !o_valid && o_ready)
		else fail_text("o_valid or o_ready wrong right after reset");

	a_no_extra: assert property (@(posedge clk) disable iff (!rst) o_valid |-> exp_cnt != 0)
		else fail_text("output present with no request in flight");

	a_pc: assert property (@(posedge clk) disable iff (!rst)
		o_valid && i_ready |-> o_pc == exp_head.pc)
		else fail_value("o_pc", $sampled(exp_head.pc), $sampled(o_pc));

	a_result: assert property (@(posedge clk) disable iff (!rst)
		o_valid && i_ready |-> o_result == exp_head.result)
		else fail_value("o_result", $sampled(exp_head.result), $sampled(o_result));

	a_br_taken: assert property (@(posedge clk) disable iff (!rst)
		o_valid && i_ready |-> o_br_taken == exp_head.br_taken)
		else fail_value("o_br_taken", $sampled(exp_head.br_taken), $sampled(o_br_taken));

	a_jump_addr: assert property (@(posedge clk) disable iff (!rst)
		o_valid && i_ready |-> o_jump_addr == exp_head.jump_addr)
		else fail_value("o_jump_addr", $sampled(exp_head.jump_addr), $sampled(o_jump_addr));

	a_expt_valid: assert property (@(posedge clk) disable iff (!rst)
		o_valid && i_ready |-> o_expt_valid == exp_head.expt_valid)
		else fail_value("o_expt_valid", $sampled(exp_head.expt_valid), $sampled(o_expt_valid));

	a_expt_cause: assert property (@(posedge clk) disable iff (!rst)
		o_valid && i_ready && exp_head.expt_valid |-> o_expt_cause == exp_head.expt_cause)
		else fail_value("o_expt_cause", $sampled(exp_head.expt_cause), $sampled(o_expt_cause));

	a_expt_value: assert property (@(posedge clk) disable iff (!rst)
		o_valid && i_ready && exp_head.expt_valid |-> o_expt_value == exp_head.expt_value)
		else fail_value("o_expt_value", $sampled(exp_head.expt_value), $sampled(o_expt_value));

	a_hold: assert property (@(posedge clk) disable iff (!rst)
		o_valid && !i_ready |=> o_valid && $stable({o_pc, o_result, o_br_taken, o_jump_addr,
			o_expt_valid, o_expt_cause, o_expt_value}))
		else fail_text("o_valid or its data changed before the transfer");

	// An empty pipeline leaves room in the output queue
	a_latency: assert property (@(posedge clk) disable iff (!rst)
		i_valid && o_ready && exp_cnt == 0 |=> !o_valid ##1 o_valid)
		else fail_text("o_valid did not rise 2 cycles after an isolated request");

	initial begin
		rst       = 1'b0;
		i_valid   = 1'b0;
		i_ready   = 1'b1;
		i_pc      = '0;
		i_itype   = INST_R;
		i_funct3  = 3'b000;
		i_alt     = 1'b0;
		i_is_jump = 1'b0;
		i_rs1     = '0;
		i_rs2     = '0;
		i_imm     = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// Isolated requests with i_ready high
		for (int i = 0; i < N_ISO; i++) begin
			send_request(i);
			i_valid = 1'b0;
			while (rcv_cnt != acc_cnt)
				next_cycle();
			next_cycle();
		end

		// Random traffic under back-pressure
		rand_ready = 1'b1;
		for (int i = N_ISO; i < N_TOTAL; i++) begin
			if (next_rand() % 4 == 0) begin
				i_valid = 1'b0;
				next_cycle();
			end
			send_request(i);
		end
		i_valid = 1'b0;
		while (rcv_cnt != acc_cnt)
			next_cycle();
		next_cycle();

		if (rcv_cnt == N_TOTAL && exp_q.size() == 0) begin
			$display("Test completed successfully");
			$finish;
		end else begin
			fail_text("number of outputs does not match the number of requests");
		end
	end

endmodule

// File: tb.f
exec_pkg.sv
exec_if.sv
op_fifo.sv
alu.sv
branch_unit.sv
exec_merge.sv
exec_unit.sv
tb_exec_unit.sv

// File: Bender.yml
package:
  name: exec_unit

sources:
  - exec_pkg.sv
  - exec_if.sv
  - op_fifo.sv
  - alu.sv
  - branch_unit.sv
  - exec_merge.sv
  - exec_unit.sv
  - target: test
    files:
      - tb_exec_unit.sv
